//--- cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_DATA_W      32
`define CPU_ADDR_W      32
`define CPU_REG_W       5
`define CPU_NOP         32'h0000_0000       // sll $0, $0, 0
`define CPU_PC_STEP     32'd4

`define CPU_OP_SPECIAL  6'b000000
`define CPU_OP_J        6'b000010
`define CPU_OP_BEQ      6'b000100
`define CPU_OP_BNE      6'b000101
`define CPU_OP_ADDI     6'b001000
`define CPU_OP_ADDIU    6'b001001
`define CPU_OP_SLTI     6'b001010
`define CPU_OP_SLTIU    6'b001011
`define CPU_OP_ANDI     6'b001100
`define CPU_OP_ORI      6'b001101
`define CPU_OP_XORI     6'b001110
`define CPU_OP_LUI      6'b001111
`define CPU_OP_LW       6'b100011
`define CPU_OP_SW       6'b101011

`define CPU_FN_SLL      6'b000000
`define CPU_FN_SRL      6'b000010
`define CPU_FN_SRA      6'b000011
`define CPU_FN_SLLV     6'b000100
`define CPU_FN_SRLV     6'b000110
`define CPU_FN_SRAV     6'b000111
`define CPU_FN_ADD      6'b100000
`define CPU_FN_ADDU     6'b100001
`define CPU_FN_SUB      6'b100010
`define CPU_FN_SUBU     6'b100011
`define CPU_FN_AND      6'b100100
`define CPU_FN_OR       6'b100101
`define CPU_FN_XOR      6'b100110
`define CPU_FN_NOR      6'b100111
`define CPU_FN_SLT      6'b101010
`define CPU_FN_SLTU     6'b101011

`define CPU_ALU_ADD     5'h00
`define CPU_ALU_SUB     5'h01
`define CPU_ALU_AND     5'h02
`define CPU_ALU_SLT     5'h03
`define CPU_ALU_OR      5'h04
`define CPU_ALU_XOR     5'h05
`define CPU_ALU_NOR     5'h06
`define CPU_ALU_SLL     5'h07
`define CPU_ALU_SRL     5'h08
`define CPU_ALU_SRA     5'h09
`define CPU_ALU_SLTU    5'h0A
`define CPU_ALU_EQ      5'h0B
`define CPU_ALU_NE      5'h0C

`define CPU_WB_ALU      2'd0
`define CPU_WB_LOAD     2'd1
`define CPU_WB_LUI      2'd2

`define CPU_DST_RD      1'b0
`define CPU_DST_RT      1'b1

`define CPU_A_RS        2'd0
`define CPU_A_RT        2'd1
`define CPU_A_ZERO      2'd2
`define CPU_A_FWD       2'd3

`define CPU_B_RT        2'd0
`define CPU_B_IMM       2'd1
`define CPU_B_SHAMT     2'd2
`define CPU_B_FWD       2'd3

`define CPU_BR_NONE     2'd0
`define CPU_BR_EQ       2'd1
`define CPU_BR_NE       2'd2

`endif

//--- cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] word_t;
    typedef logic [`CPU_ADDR_W-1:0] addr_t;     // byte address
    typedef logic [`CPU_REG_W-1:0]  reg_idx_t;

    typedef logic [4:0] alu_op_t;
    typedef logic [1:0] a_sel_t;
    typedef logic [1:0] b_sel_t;
    typedef logic [1:0] wb_sel_t;               // alu, load or lui
    typedef logic       dst_sel_t;              // rd or rt
    typedef logic [1:0] br_sel_t;

endpackage

//--- fetch_decode.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module fetch_decode (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_stall,
    input  cpu_pkg::word_t     i_inst,
    input  logic               i_inst_valid,
    input  cpu_pkg::reg_idx_t  i_wb_dst,
    input  logic               i_redirect,
    input  cpu_pkg::addr_t     i_redirect_pc,
    output cpu_pkg::addr_t     o_inst_addr,
    output cpu_pkg::word_t     o_inst,
    output cpu_pkg::addr_t     o_pc,
    output logic               o_reg_we,
    output cpu_pkg::wb_sel_t   o_wb_sel,
    output cpu_pkg::dst_sel_t  o_dst_sel,
    output cpu_pkg::alu_op_t   o_alu_op,
    output cpu_pkg::a_sel_t    o_a_sel,
    output cpu_pkg::b_sel_t    o_b_sel,
    output logic               o_sign_ext,
    output logic               o_mem_r,
    output logic               o_mem_w,
    output cpu_pkg::br_sel_t   o_br_sel
);

    cpu_pkg::addr_t    pc;
    cpu_pkg::addr_t    pc_next;
    cpu_pkg::reg_idx_t d_dst;
    cpu_pkg::a_sel_t   base_a;
    cpu_pkg::b_sel_t   base_b;
    logic              rs_fwd;
    logic              rt_fwd;
    logic              br_in_exec;
    logic              br_in_mem;
    logic              br_in_wb;
    logic              bubble;
    logic              pc_freeze;

    logic [5:0]        d_op;
    logic [5:0]        d_fn;
    cpu_pkg::reg_idx_t d_rs;
    cpu_pkg::reg_idx_t d_rt;
    cpu_pkg::reg_idx_t d_rd;
    logic [5:0]        n_op;
    cpu_pkg::reg_idx_t n_rs;
    cpu_pkg::reg_idx_t n_rt;

    // predecode of the incoming word
    function automatic logic uses_rs(cpu_pkg::word_t w);
        logic [5:0] fn;
        fn = w[5:0];
        case (w[31:26])
            `CPU_OP_SPECIAL: uses_rs = !(fn == `CPU_FN_SLL || fn == `CPU_FN_SRL ||
                                         fn == `CPU_FN_SRA);
            `CPU_OP_J, `CPU_OP_LUI: uses_rs = 1'b0;
            default: uses_rs = 1'b1;
        endcase
    endfunction

    function automatic logic uses_rt(cpu_pkg::word_t w);
        case (w[31:26])
            `CPU_OP_SPECIAL, `CPU_OP_SW, `CPU_OP_BEQ, `CPU_OP_BNE: uses_rt = 1'b1;
            default: uses_rt = 1'b0;
        endcase
    endfunction

    assign d_op = o_inst[31:26];
    assign d_fn = o_inst[5:0];
    assign d_rs = o_inst[25:21];
    assign d_rt = o_inst[20:16];
    assign d_rd = o_inst[15:11];
    assign n_op = i_inst[31:26];
    assign n_rs = i_inst[25:21];
    assign n_rt = i_inst[20:16];

    assign rs_fwd = (d_rs != '0) && (d_rs == i_wb_dst);     // result sits in writeback reg
    assign rt_fwd = (d_rt != '0) && (d_rt == i_wb_dst);

    always_comb begin
        o_reg_we   = 1'b0;
        o_wb_sel   = `CPU_WB_ALU;
        o_dst_sel  = `CPU_DST_RD;
        o_alu_op   = `CPU_ALU_ADD;
        base_a     = `CPU_A_RS;
        base_b     = `CPU_B_RT;
        o_sign_ext = 1'b0;
        o_mem_r    = 1'b0;
        o_mem_w    = 1'b0;
        o_br_sel   = `CPU_BR_NONE;
        case (d_op)
            `CPU_OP_SPECIAL: begin
                o_reg_we = 1'b1;
                case (d_fn)
                    `CPU_FN_ADD, `CPU_FN_ADDU: o_alu_op = `CPU_ALU_ADD;
                    `CPU_FN_SUB, `CPU_FN_SUBU: o_alu_op = `CPU_ALU_SUB;
                    `CPU_FN_AND:               o_alu_op = `CPU_ALU_AND;
                    `CPU_FN_OR:                o_alu_op = `CPU_ALU_OR;
                    `CPU_FN_XOR:               o_alu_op = `CPU_ALU_XOR;
                    `CPU_FN_NOR:               o_alu_op = `CPU_ALU_NOR;
                    `CPU_FN_SLT:               o_alu_op = `CPU_ALU_SLT;
                    `CPU_FN_SLTU:              o_alu_op = `CPU_ALU_SLTU;
                    `CPU_FN_SLL, `CPU_FN_SLLV: o_alu_op = `CPU_ALU_SLL;
                    `CPU_FN_SRL, `CPU_FN_SRLV: o_alu_op = `CPU_ALU_SRL;
                    `CPU_FN_SRA, `CPU_FN_SRAV: o_alu_op = `CPU_ALU_SRA;
                    default:                   o_reg_we = 1'b0;
                endcase
                if (d_fn[5:3] == 3'b000) begin      // shifts act on rt
                    base_a = `CPU_A_RT;
                    base_b = `CPU_B_SHAMT;
                end
            end
            `CPU_OP_ADDI, `CPU_OP_ADDIU, `CPU_OP_SLTI, `CPU_OP_SLTIU,
            `CPU_OP_ANDI, `CPU_OP_ORI, `CPU_OP_XORI, `CPU_OP_LUI: begin
                o_reg_we   = 1'b1;
                o_dst_sel  = `CPU_DST_RT;
                base_b     = `CPU_B_IMM;
                o_sign_ext = (d_op[2] == 1'b0);      // logical immediates zero-extend
                case (d_op)
                    `CPU_OP_SLTI:              o_alu_op = `CPU_ALU_SLT;
                    `CPU_OP_SLTIU:             o_alu_op = `CPU_ALU_SLTU;
                    `CPU_OP_ANDI:              o_alu_op = `CPU_ALU_AND;
                    `CPU_OP_ORI:               o_alu_op = `CPU_ALU_OR;
                    `CPU_OP_XORI, `CPU_OP_LUI: o_alu_op = `CPU_ALU_XOR;
                    default:                   o_alu_op = `CPU_ALU_ADD;
                endcase
                if (d_op == `CPU_OP_LUI) begin
                    base_a   = `CPU_A_ZERO;
                    o_wb_sel = `CPU_WB_LUI;
                end
            end
            `CPU_OP_LW: begin
                o_reg_we   = 1'b1;
                o_dst_sel  = `CPU_DST_RT;
                o_wb_sel   = `CPU_WB_LOAD;
                base_b     = `CPU_B_IMM;
                o_sign_ext = 1'b1;
                o_mem_r    = 1'b1;
            end
            `CPU_OP_SW: begin
                base_b     = `CPU_B_IMM;
                o_sign_ext = 1'b1;
                o_mem_w    = 1'b1;
            end
            `CPU_OP_BEQ: begin
                o_alu_op = `CPU_ALU_EQ;
                o_br_sel = `CPU_BR_EQ;
            end
            `CPU_OP_BNE: begin
                o_alu_op = `CPU_ALU_NE;
                o_br_sel = `CPU_BR_NE;
            end
            default: ;
        endcase

        o_a_sel = base_a;
        if ((base_a == `CPU_A_RS && rs_fwd) || (base_a == `CPU_A_RT && rt_fwd))
            o_a_sel = `CPU_A_FWD;
        o_b_sel = base_b;
        // on a store, fwd marks the store data and the address keeps the immediate
        if ((base_b == `CPU_B_RT && rt_fwd) || (o_mem_w && rt_fwd) ||
            (base_b == `CPU_B_SHAMT && d_fn[2] && rs_fwd))
            o_b_sel = `CPU_B_FWD;
    end

    assign d_dst = !o_reg_we ? '0 :
                   (o_dst_sel == `CPU_DST_RD) ? d_rd : d_rt;

    assign br_in_exec = (o_br_sel != `CPU_BR_NONE);
    assign bubble     = !i_inst_valid || br_in_exec || br_in_mem || br_in_wb ||
                        (uses_rs(i_inst) && n_rs != '0 && n_rs == d_dst) ||
                        (uses_rt(i_inst) && n_rt != '0 && n_rt == d_dst);

    // a branch holds the pc until memory sends the target
    assign pc_freeze = (bubble || n_op == `CPU_OP_BEQ || n_op == `CPU_OP_BNE) && !i_redirect;
    assign pc_next   = i_redirect ? i_redirect_pc :
                       (n_op == `CPU_OP_J) ? {pc[31:28], i_inst[25:0], 2'b00} :
                       pc + `CPU_PC_STEP;

    assign o_inst_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            o_inst    <= `CPU_NOP;
            o_pc      <= '0;
            br_in_mem <= 1'b0;
            br_in_wb  <= 1'b0;
        end else if (!i_stall) begin
            pc        <= pc_freeze ? pc : pc_next;
            o_inst    <= bubble ? `CPU_NOP : i_inst;
            o_pc      <= pc;
            br_in_mem <= br_in_exec;
            br_in_wb  <= br_in_mem;
        end
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module execute_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_stall,
    input  cpu_pkg::word_t     i_inst,
    input  cpu_pkg::addr_t     i_pc,
    input  logic               i_reg_we,
    input  cpu_pkg::wb_sel_t   i_wb_sel,
    input  cpu_pkg::dst_sel_t  i_dst_sel,
    input  cpu_pkg::alu_op_t   i_alu_op,
    input  cpu_pkg::a_sel_t    i_a_sel,
    input  cpu_pkg::b_sel_t    i_b_sel,
    input  logic               i_sign_ext,
    input  logic               i_mem_r,
    input  logic               i_mem_w,
    input  cpu_pkg::br_sel_t   i_br_sel,
    input  cpu_pkg::word_t     i_rs_data,
    input  cpu_pkg::word_t     i_rt_data,
    input  cpu_pkg::word_t     i_fwd,
    output cpu_pkg::reg_idx_t  o_rs_idx,
    output cpu_pkg::reg_idx_t  o_rt_idx,
    output cpu_pkg::word_t     o_inst,
    output cpu_pkg::addr_t     o_pc,
    output logic               o_reg_we,
    output cpu_pkg::wb_sel_t   o_wb_sel,
    output cpu_pkg::dst_sel_t  o_dst_sel,
    output logic               o_mem_r,
    output logic               o_mem_w,
    output cpu_pkg::br_sel_t   o_br_sel,
    output cpu_pkg::word_t     o_result,
    output cpu_pkg::word_t     o_store_data
);

    cpu_pkg::word_t imm;
    cpu_pkg::word_t alu_a;
    cpu_pkg::word_t alu_b;
    cpu_pkg::word_t alu_out;

    assign o_rs_idx = i_inst[25:21];
    assign o_rt_idx = i_inst[20:16];

    assign imm = {{16{i_sign_ext & i_inst[15]}}, i_inst[15:0]};

    always_comb begin
        case (i_a_sel)
            `CPU_A_RS:   alu_a = i_rs_data;
            `CPU_A_RT:   alu_a = i_rt_data;
            `CPU_A_ZERO: alu_a = '0;
            default:     alu_a = i_fwd;
        endcase
        case (i_b_sel)
            `CPU_B_RT:    alu_b = i_rt_data;
            `CPU_B_IMM:   alu_b = imm;
            `CPU_B_SHAMT: alu_b = i_inst[2] ? i_rs_data : cpu_pkg::word_t'(i_inst[10:6]);
            default:      alu_b = i_mem_w ? imm : i_fwd;
        endcase
    end

    always_comb begin
        case (i_alu_op)
            `CPU_ALU_ADD:  alu_out = alu_a + alu_b;
            `CPU_ALU_SUB:  alu_out = alu_a - alu_b;
            `CPU_ALU_AND:  alu_out = alu_a & alu_b;
            `CPU_ALU_SLT:  alu_out = cpu_pkg::word_t'($signed(alu_a) < $signed(alu_b));
            `CPU_ALU_OR:   alu_out = alu_a | alu_b;
            `CPU_ALU_XOR:  alu_out = alu_a ^ alu_b;
            `CPU_ALU_NOR:  alu_out = ~(alu_a | alu_b);
            `CPU_ALU_SLL:  alu_out = alu_a << alu_b[4:0];
            `CPU_ALU_SRL:  alu_out = alu_a >> alu_b[4:0];
            `CPU_ALU_SRA:  alu_out = $signed(alu_a) >>> alu_b[4:0];
            `CPU_ALU_SLTU: alu_out = cpu_pkg::word_t'(alu_a < alu_b);
            `CPU_ALU_EQ:   alu_out = cpu_pkg::word_t'(alu_a == alu_b);
            `CPU_ALU_NE:   alu_out = cpu_pkg::word_t'(alu_a != alu_b);
            default:       alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_reg_we  <= 1'b0;
            o_wb_sel  <= `CPU_WB_ALU;
            o_dst_sel <= `CPU_DST_RD;
            o_mem_r   <= 1'b0;
            o_mem_w   <= 1'b0;
            o_br_sel  <= `CPU_BR_NONE;
        end else if (!i_stall) begin
            o_reg_we  <= i_reg_we;
            o_wb_sel  <= i_wb_sel;
            o_dst_sel <= i_dst_sel;
            o_mem_r   <= i_mem_r;
            o_mem_w   <= i_mem_w;
            o_br_sel  <= i_br_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_inst       <= i_inst;
            o_pc         <= i_pc;
            o_result     <= alu_out;
            o_store_data <= (i_b_sel == `CPU_B_FWD) ? i_fwd : i_rt_data;
        end
    end

endmodule

//--- memory_stage.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module memory_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_stall,
    input  cpu_pkg::word_t     i_inst,
    input  cpu_pkg::addr_t     i_pc,
    input  logic               i_reg_we,
    input  cpu_pkg::wb_sel_t   i_wb_sel,
    input  cpu_pkg::dst_sel_t  i_dst_sel,
    input  logic               i_mem_r,
    input  logic               i_mem_w,
    input  cpu_pkg::br_sel_t   i_br_sel,
    input  cpu_pkg::word_t     i_result,
    input  cpu_pkg::word_t     i_store_data,
    input  cpu_pkg::word_t     i_data_in,
    output cpu_pkg::addr_t     o_data_addr,
    output cpu_pkg::word_t     o_data_out,
    output logic               o_data_we,
    output logic               o_data_rd,
    output logic               o_wb_we,
    output cpu_pkg::reg_idx_t  o_wb_idx,
    output cpu_pkg::word_t     o_wb_data,
    output logic               o_redirect,
    output cpu_pkg::addr_t     o_redirect_pc
);

    cpu_pkg::word_t    wb_next;
    cpu_pkg::reg_idx_t dst_idx;
    cpu_pkg::addr_t    seq_pc;
    cpu_pkg::addr_t    br_offset;

    assign o_data_addr = i_result;
    assign o_data_out  = i_store_data;
    assign o_data_we   = i_mem_w;
    assign o_data_rd   = i_mem_r;

    always_comb begin
        case (i_wb_sel)
            `CPU_WB_LOAD: wb_next = i_data_in;
            `CPU_WB_LUI:  wb_next = {i_result[15:0], 16'b0};
            default:      wb_next = i_result;
        endcase
    end

    // zero index when nothing is written, so decode never forwards from it
    assign dst_idx   = !i_reg_we ? '0 :
                       (i_dst_sel == `CPU_DST_RD) ? i_inst[15:11] : i_inst[20:16];
    assign seq_pc    = i_pc + `CPU_PC_STEP;
    assign br_offset = {{14{i_inst[15]}}, i_inst[15:0], 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            o_wb_we    <= 1'b0;
            o_wb_idx   <= '0;
            o_redirect <= 1'b0;
        end else if (!i_stall) begin
            o_wb_we    <= i_reg_we;
            o_wb_idx   <= dst_idx;
            o_redirect <= (i_br_sel != `CPU_BR_NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_wb_data     <= wb_next;
            o_redirect_pc <= (|i_result) ? seq_pc + br_offset : seq_pc;     // taken on nonzero
        end
    end

endmodule

//--- reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_idx_t  i_rs_idx,
    input  cpu_pkg::reg_idx_t  i_rt_idx,
    input  logic               i_we,
    input  cpu_pkg::reg_idx_t  i_w_idx,
    input  cpu_pkg::word_t     i_w_data,
    output cpu_pkg::word_t     o_rs_data,
    output cpu_pkg::word_t     o_rt_data
);

    cpu_pkg::word_t regs [1:31];    // $0 has no storage

    assign o_rs_data = (i_rs_idx == '0) ? '0 : regs[i_rs_idx];
    assign o_rt_data = (i_rt_idx == '0) ? '0 : regs[i_rt_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (i_we && i_w_idx != '0) begin
            regs[i_w_idx] <= i_w_data;
        end
    end

endmodule

//--- cpu_core.sv
`timescale 1ns/10ps

module cpu_core (
    input  logic            clk,
    input  logic            rst,
    output cpu_pkg::addr_t  o_inst_addr,
    input  cpu_pkg::word_t  i_inst,
    input  logic            i_inst_valid,
    output cpu_pkg::addr_t  o_data_addr,
    input  cpu_pkg::word_t  i_data_in,
    output cpu_pkg::word_t  o_data_out,
    output logic            o_data_we,
    output logic            o_data_rd,
    input  logic            i_data_ready
);

    logic              stall;

    cpu_pkg::word_t    fd_inst;
    cpu_pkg::addr_t    fd_pc;
    logic              fd_reg_we;
    cpu_pkg::wb_sel_t  fd_wb_sel;
    cpu_pkg::dst_sel_t fd_dst_sel;
    cpu_pkg::alu_op_t  fd_alu_op;
    cpu_pkg::a_sel_t   fd_a_sel;
    cpu_pkg::b_sel_t   fd_b_sel;
    logic              fd_sign_ext;
    logic              fd_mem_r;
    logic              fd_mem_w;
    cpu_pkg::br_sel_t  fd_br_sel;

    cpu_pkg::reg_idx_t ex_rs_idx;
    cpu_pkg::reg_idx_t ex_rt_idx;
    cpu_pkg::word_t    ex_inst;
    cpu_pkg::addr_t    ex_pc;
    logic              ex_reg_we;
    cpu_pkg::wb_sel_t  ex_wb_sel;
    cpu_pkg::dst_sel_t ex_dst_sel;
    logic              ex_mem_r;
    logic              ex_mem_w;
    cpu_pkg::br_sel_t  ex_br_sel;
    cpu_pkg::word_t    ex_result;
    cpu_pkg::word_t    ex_store_data;

    cpu_pkg::word_t    rf_rs_data;
    cpu_pkg::word_t    rf_rt_data;
    logic              wb_we;
    cpu_pkg::reg_idx_t wb_idx;
    cpu_pkg::word_t    wb_data;
    logic              redirect;
    cpu_pkg::addr_t    redirect_pc;

    assign stall = ~i_data_ready;

    fetch_decode i_fetch_decode (
        .clk           (clk),
        .rst           (rst),
        .i_stall       (stall),
        .i_inst        (i_inst),
        .i_inst_valid  (i_inst_valid),
        .i_wb_dst      (wb_idx),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_inst_addr   (o_inst_addr),
        .o_inst        (fd_inst),
        .o_pc          (fd_pc),
        .o_reg_we      (fd_reg_we),
        .o_wb_sel      (fd_wb_sel),
        .o_dst_sel     (fd_dst_sel),
        .o_alu_op      (fd_alu_op),
        .o_a_sel       (fd_a_sel),
        .o_b_sel       (fd_b_sel),
        .o_sign_ext    (fd_sign_ext),
        .o_mem_r       (fd_mem_r),
        .o_mem_w       (fd_mem_w),
        .o_br_sel      (fd_br_sel)
    );

    execute_stage i_execute_stage (
        .clk          (clk),
        .rst          (rst),
        .i_stall      (stall),
        .i_inst       (fd_inst),
        .i_pc         (fd_pc),
        .i_reg_we     (fd_reg_we),
        .i_wb_sel     (fd_wb_sel),
        .i_dst_sel    (fd_dst_sel),
        .i_alu_op     (fd_alu_op),
        .i_a_sel      (fd_a_sel),
        .i_b_sel      (fd_b_sel),
        .i_sign_ext   (fd_sign_ext),
        .i_mem_r      (fd_mem_r),
        .i_mem_w      (fd_mem_w),
        .i_br_sel     (fd_br_sel),
        .i_rs_data    (rf_rs_data),
        .i_rt_data    (rf_rt_data),
        .i_fwd        (wb_data),
        .o_rs_idx     (ex_rs_idx),
        .o_rt_idx     (ex_rt_idx),
        .o_inst       (ex_inst),
        .o_pc         (ex_pc),
        .o_reg_we     (ex_reg_we),
        .o_wb_sel     (ex_wb_sel),
        .o_dst_sel    (ex_dst_sel),
        .o_mem_r      (ex_mem_r),
        .o_mem_w      (ex_mem_w),
        .o_br_sel     (ex_br_sel),
        .o_result     (ex_result),
        .o_store_data (ex_store_data)
    );

    memory_stage i_memory_stage (
        .clk           (clk),
        .rst           (rst),
        .i_stall       (stall),
        .i_inst        (ex_inst),
        .i_pc          (ex_pc),
        .i_reg_we      (ex_reg_we),
        .i_wb_sel      (ex_wb_sel),
        .i_dst_sel     (ex_dst_sel),
        .i_mem_r       (ex_mem_r),
        .i_mem_w       (ex_mem_w),
        .i_br_sel      (ex_br_sel),
        .i_result      (ex_result),
        .i_store_data  (ex_store_data),
        .i_data_in     (i_data_in),
        .o_data_addr   (o_data_addr),
        .o_data_out    (o_data_out),
        .o_data_we     (o_data_we),
        .o_data_rd     (o_data_rd),
        .o_wb_we       (wb_we),
        .o_wb_idx      (wb_idx),
        .o_wb_data     (wb_data),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .rst       (rst),
        .i_rs_idx  (ex_rs_idx),
        .i_rt_idx  (ex_rt_idx),
        .i_we      (wb_we),
        .i_w_idx   (wb_idx),
        .i_w_data  (wb_data),
        .o_rs_data (rf_rs_data),
        .o_rt_data (rf_rt_data)
    );

endmodule

//--- cpu_chk.sv
`timescale 1ns/10ps

module cpu_chk (
    input logic            clk,
    input logic            rst,
    input logic            i_data_ready,
    input logic            i_data_we,
    input logic            i_data_rd,
    input cpu_pkg::addr_t  i_data_addr,
    input cpu_pkg::word_t  i_data_out,
    input cpu_pkg::addr_t  i_inst_addr
);

    int fail_count = 0;

    no_we_with_rd: assert property (@(posedge clk) disable iff (rst)
        !(i_data_we && i_data_rd))
        else begin
            fail_count++;
            $error("o_data_we and o_data_rd high together");
        end

    // the memory stage holds its bus while the data side is not ready
    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        !i_data_ready |=> ($stable(i_data_addr) && $stable(i_data_out) &&
                           $stable(i_data_we) && $stable(i_data_rd)))
        else begin
            fail_count++;
            $error("data bus changed while i_data_ready was low");
        end

    inst_aligned: assert property (@(posedge clk) disable iff (rst)
        i_inst_addr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("o_inst_addr not word aligned");
        end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!i_data_we && !i_data_rd))
        else begin
            fail_count++;
            $error("bus strobes high in the cycle after reset");
        end

endmodule

bind cpu_core cpu_chk i_cpu_chk (
    .clk          (clk),
    .rst          (rst),
    .i_data_ready (i_data_ready),
    .i_data_we    (o_data_we),
    .i_data_rd    (o_data_rd),
    .i_data_addr  (o_data_addr),
    .i_data_out   (o_data_out),
    .i_inst_addr  (o_inst_addr)
);

//--- cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

    localparam int          MEM_WORDS = 64;
    localparam int          MAX_EXP   = 64;
    localparam logic [31:0] DONE_ADDR = 32'h0000_00FC;     // marker store ends a run

    logic        clk;
    logic        rst;
    logic [31:0] inst_addr;
    logic [31:0] inst;
    logic        inst_valid;
    logic [31:0] data_addr;
    logic [31:0] data_in;
    logic [31:0] data_out;
    logic        data_we;
    logic        data_rd;
    logic        data_ready;

    logic [31:0] imem [0:MEM_WORDS-1];
    logic [31:0] dmem [0:MEM_WORDS-1];
    logic [31:0] init_addr [0:MAX_EXP-1];
    logic [31:0] init_data [0:MAX_EXP-1];
    int          init_count;
    int          prog_len;
    logic [31:0] stall_mask;
    logic [31:0] valid_mask;
    int          exp_test [0:MAX_EXP-1];
    logic [31:0] exp_addr [0:MAX_EXP-1];
    logic [31:0] exp_data [0:MAX_EXP-1];
    int          exp_count;
    int          test_count;
    logic [31:0] got_addr [0:MAX_EXP-1];
    logic [31:0] got_data [0:MAX_EXP-1];
    int          got_count;
    int          checks;
    int          errors;
    int          test_errors;
    bit          timed_out;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    assign inst    = imem[inst_addr[7:2]];
    assign data_in = data_rd ? dmem[data_addr[7:2]] : '0;     // only driven on a read

    cpu_core i_cpu_core (
        .clk          (clk),
        .rst          (rst),
        .o_inst_addr  (inst_addr),
        .i_inst       (inst),
        .i_inst_valid (inst_valid),
        .o_data_addr  (data_addr),
        .i_data_in    (data_in),
        .o_data_out   (data_out),
        .o_data_we    (data_we),
        .o_data_rd    (data_rd),
        .i_data_ready (data_ready)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("error: %s expected %h got %h", name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic read_golden();
        int               fd;
        int               n;
        int               t;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [7:0]       tag;
        logic [8*160-1:0] rest;
        bit               more;
        for (int i = 0; i < MEM_WORDS; i++)
            imem[i] = {6'b000010, 26'(i)};          // j to itself
        prog_len   = 0;
        init_count = 0;
        exp_count  = 0;
        test_count = 0;
        stall_mask = '0;
        valid_mask = '0;
        fd = $fopen("cpu_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open cpu_golden.txt");
            errors++;
        end else begin
            more = 1'b1;
            while (more && !$feof(fd)) begin
                n = $fscanf(fd, "%s", tag);
                if (n != 1) begin
                    more = 1'b0;
                end else if (tag == "p" && prog_len < MEM_WORDS) begin
                    n = $fscanf(fd, "%h", a);
                    imem[prog_len] = a;
                    prog_len++;
                end else if (tag == "d" && init_count < MAX_EXP) begin
                    n = $fscanf(fd, "%h %h", a, b);
                    init_addr[init_count] = a;
                    init_data[init_count] = b;
                    init_count++;
                end else if (tag == "s") begin
                    n = $fscanf(fd, "%h", stall_mask);
                end else if (tag == "v") begin
                    n = $fscanf(fd, "%h", valid_mask);
                end else if (tag == "e" && exp_count < MAX_EXP) begin
                    n = $fscanf(fd, "%d %h %h", t, a, b);
                    exp_test[exp_count] = t;
                    exp_addr[exp_count] = a;
                    exp_data[exp_count] = b;
                    exp_count++;
                    if (t > test_count)
                        test_count = t;
                end else begin
                    n = $fgets(rest, fd);           // comment or unknown record
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic load_data_memory();
        for (int i = 0; i < MEM_WORDS; i++)
            dmem[i] = 32'h5A5A_0000 | (i << 2);
        for (int i = 0; i < init_count; i++)
            dmem[init_addr[i][7:2]] = init_data[i];
    endtask

    // mode 0 clean, mode 1 golden masks, mode 2 random drops
    task automatic run_program(input int mode);
        int cycle;
        int stall_cycles;
        int limit;
        bit done;
        bit ready;
        bit valid;
        @(negedge clk);
        rst        = 1'b1;
        data_ready = 1'b1;
        inst_valid = 1'b1;
        load_data_memory();
        got_count = 0;
        repeat (10) @(negedge clk);
        rst          = 1'b0;
        cycle        = 0;
        stall_cycles = 0;
        done         = 1'b0;
        limit        = 4 * prog_len + 50;
        while (!done && !timed_out) begin
            @(negedge clk);
            ready = 1'b1;
            valid = 1'b1;
            if (mode == 1) begin
                ready = !stall_mask[cycle % 32];
                valid = !valid_mask[cycle % 32];
            end else if (mode == 2) begin
                ready = ($urandom % 32'd4) != 32'd0;
                valid = ($urandom % 32'd6) != 32'd0;
            end
            data_ready = ready;
            inst_valid = valid;
            if (!ready || !valid)
                stall_cycles++;
            // bus is stable until the next rising edge, which commits the store
            if (data_we && ready) begin
                if (data_addr == DONE_ADDR) begin
                    done = 1'b1;
                end else if (got_count < MAX_EXP) begin
                    got_addr[got_count] = data_addr;
                    got_data[got_count] = data_out;
                    got_count++;
                end
                dmem[data_addr[7:2]] = data_out;
            end
            cycle++;
            if (!done && cycle > limit + stall_cycles) begin
                $display("run %0d timed out after %0d cycles without the end marker store",
                         mode, cycle);
                timed_out = 1'b1;
                errors++;
            end
        end
    endtask

    task automatic report_run(input int mode);
        int    n;
        string status;
        for (int t = 1; t <= test_count; t++) begin
            test_errors = 0;
            n = 0;
            for (int e = 0; e < exp_count; e++) begin
                if (exp_test[e] == t) begin
                    if (e >= got_count) begin
                        $display("store %0d of test %0d never happened", n, t);
                        errors++;
                        test_errors++;
                    end else begin
                        check_value("o_data_addr", exp_addr[e], got_addr[e]);
                        check_value("o_data_out", exp_data[e], got_data[e]);
                    end
                    n++;
                end
            end
            status = (test_errors == 0) ? "ok" : "failed";
            $display("run %0d test %0d: %0d stores, %s", mode, t, n, status);
        end
        if (got_count > exp_count) begin
            $display("run %0d made %0d stores more than expected", mode, got_count - exp_count);
            errors++;
        end
    endtask

    initial begin
        int mode;
        checks     = 0;
        errors     = 0;
        timed_out  = 1'b0;
        rst        = 1'b1;
        data_ready = 1'b1;
        inst_valid = 1'b1;
        void'($urandom(32'h471aadd9));
        read_golden();
        for (mode = 0; mode < 3 && !timed_out && prog_len > 0; mode++) begin
            run_program(mode);
            if (!timed_out)
                report_run(mode);
        end
        if (checks == 0) begin
            $display("no store was checked");
            errors++;
        end
        errors += i_cpu_core.i_cpu_chk.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, i_cpu_core.i_cpu_chk.fail_count);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- cpu_golden.txt
# p word | d addr word | s stall mask | v inst_valid gap mask | e test addr data (hex)
# mask bit n drops the signal on cycles n, n+32, ... of the masked run
s 10a40c21
v 02104084
d 00000080 cafef00d
# test 1: alu and immediate instructions
p 3c011234
p 34215678
p 2402fffd
p 00221821
p ac030040
p 00222022
p ac040044
p 00222827
p ac050048
p 0041302a
p 0041382b
p ac06004c
p ac070050
p 00024103
p 00014a00
p ac080054
p ac090058
p 00c15006
p 304bff0f
p ac0a005c
p ac0b0060
p 382c00ff
p 284dfffe
p ac0c0064
p ac0d0068
# test 2: dependent chain
p 200e0005
p 01ce7820
p 01cf7804
p ac0f006c
p 01ee8023
p ac100070
# test 3: memory round trip
p 8c110080
p ac110084
p 8c120084
p ac120088
# test 4: beq taken, bne not taken, j
p 11ce0002
p ac000090
p ac000094
p 15ce0001
p ac0e0098
p 0800002a
p ac00009c
p ac10009c
# end marker store
p ac0e00fc
e 1 00000040 12345675
e 1 00000044 1234567b
e 1 00000048 00000002
e 1 0000004c 00000001
e 1 00000050 00000000
e 1 00000054 ffffffff
e 1 00000058 34567800
e 1 0000005c 091a2b3c
e 1 00000060 0000ff0d
e 1 00000064 12345687
e 1 00000068 00000001
e 2 0000006c 00000140
e 2 00000070 0000013b
e 3 00000084 cafef00d
e 3 00000088 cafef00d
e 4 00000098 00000005
e 4 0000009c 0000013b

//--- sources.f
+incdir+.
cpu_pkg.sv
fetch_decode.sv
execute_stage.sv
memory_stage.sv
reg_file.sv
cpu_core.sv
cpu_chk.sv
cpu_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -f sources.f -o cpu_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/cpu_sim +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
